// ==== sar_sense.f ====
src/sar_conf_pkg.sv
src/sar_data_pkg.sv
src/sar_conf_regs.sv
src/sar_emulator.sv
src/sar_decimator.sv
src/sar_sense_top.sv
test/sar_clk_gen.sv
test/sar_sense_tb.sv

// ==== src/sar_conf_pkg.sv ====
package sar_conf_pkg;

   ////////////////////
   // Bus geometry
   ////////////////////

   localparam int CONF_DATA_W = 16;
   localparam int CONF_OFFS_W = 4;

   // Register offsets
   localparam logic [CONF_OFFS_W-1:0] OFFS_CTRL   = 4'd0;
   localparam logic [CONF_OFFS_W-1:0] OFFS_PERIOD = 4'd1;

   ////////////////////
   // Register layouts
   ////////////////////

   // Control word, enable in bit 0
   typedef struct packed {
      logic [11:0] rsvd;
      logic [1:0]  avg_log2;
      logic        pattern_sel;
      logic        conv_en;
   } sar_ctrl_t;

   // Period word, idle length in the low byte
   typedef struct packed {
      logic [7:0] rsvd;
      logic [7:0] period_cnt;
   } sar_period_t;

   // One bus word, two views picked by offset
   typedef union packed {
      sar_ctrl_t   ctrl;
      sar_period_t period;
   } conf_word_u;

   // Live configuration held by the register file
   typedef struct packed {
      logic       conv_en;
      logic       pattern_sel;
      logic [1:0] avg_log2;
      logic [7:0] period_cnt;
   } sar_cfg_t;

endpackage

// ==== src/sar_conf_regs.sv ====
`timescale 1ns/1ns

module sar_conf_regs
   import sar_conf_pkg::*;
#(
   parameter int unsigned PERIOD_RST = 255
) (
   input  logic                   ana_del_clk,
   input  logic                   rst_n,

   // Configuration bus
   input  logic                   block_en_i,
   input  logic [CONF_DATA_W-1:0] conf_data_i,
   input  logic [CONF_OFFS_W-1:0] conf_offset_i,

   // Held configuration
   output sar_cfg_t               cfg_o
);

   ////////////////////
   // Word decode
   ////////////////////

   conf_word_u word;
   sar_cfg_t   cfg_q;

   // Same bits, read as control or period
   assign word = conf_data_i;

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge ana_del_clk, negedge rst_n) begin
      if (!rst_n) begin
         // Output disabled, longest idle
         cfg_q.conv_en     <= 1'b0;
         cfg_q.pattern_sel <= 1'b0;
         cfg_q.avg_log2    <= 2'd0;
         cfg_q.period_cnt  <= 8'(PERIOD_RST);
      end else if (block_en_i) begin
         case (conf_offset_i)
            OFFS_CTRL: begin
               // Reserved bits dropped
               cfg_q.conv_en     <= word.ctrl.conv_en;
               cfg_q.pattern_sel <= word.ctrl.pattern_sel;
               cfg_q.avg_log2    <= word.ctrl.avg_log2;
            end
            OFFS_PERIOD: begin
               cfg_q.period_cnt <= word.period.period_cnt;
            end
            default: begin
               // Unknown offset, nothing changes
               cfg_q <= cfg_q;
            end
         endcase
      end
   end

   // Visible one cycle after the strobe
   assign cfg_o = cfg_q;

   ////////////////////
   // Checks
   ////////////////////

   // Offset must be resolved whenever a write is strobed
   a_offs_known : assert property (
      @(posedge ana_del_clk) disable iff (!rst_n)
      block_en_i |-> !$isunknown(conf_offset_i)
   );

endmodule

// ==== src/sar_data_pkg.sv ====
package sar_data_pkg;

   ////////////////////
   // LFSR constants
   ////////////////////

   // Galois form, shifts right
   localparam int LFSR_W = 16;

   // Tap mask for a maximal length sequence
   localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

   // Any nonzero start value works
   localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;

   ////////////////////
   // Conversion types
   ////////////////////

   // Raw conversion at full LFSR width
   // Trimmed to the converter width at the emulator output
   typedef struct packed {
      logic              valid;
      logic [LFSR_W-1:0] word;
   } sar_conv_t;

endpackage

// ==== src/sar_decimator.sv ====
`timescale 1ns/1ns

module sar_decimator
   import sar_conf_pkg::*;
#(
   parameter int SAR_DATA_W = 8
) (
   input  logic                  ana_del_clk,
   input  logic                  rst_n,

   input  sar_cfg_t              cfg_i,

   // Conversions in
   input  logic [SAR_DATA_W-1:0] conv_data_i,
   input  logic                  conv_valid_i,

   // Block means out
   output logic [SAR_DATA_W-1:0] avg_data_o,
   output logic                  avg_valid_o
);

   // Room for a sum of eight words
   localparam int ACC_W = SAR_DATA_W + 3;
   localparam int CNT_W = 4;

   logic [ACC_W-1:0]      acc_q, acc_base, acc_sum, mean;
   logic [CNT_W-1:0]      cnt_q, cnt_base, cnt_inc, blk_len;
   logic [1:0]            log2_q;
   logic                  restart;
   logic                  blk_done;
   logic [SAR_DATA_W-1:0] avg_data_q;
   logic                  avg_valid_q;

   ////////////////////
   // Accumulate
   ////////////////////

   // Block of 1, 2, 4 or 8
   assign blk_len = CNT_W'(1) << cfg_i.avg_log2;

   always_comb begin
      // New block size drops the partial sum
      restart  = (cfg_i.avg_log2 != log2_q);
      acc_base = restart ? '0 : acc_q;
      cnt_base = restart ? '0 : cnt_q;
      acc_sum  = acc_base + ACC_W'(conv_data_i);
      cnt_inc  = cnt_base + 1'b1;
      blk_done = conv_valid_i && (cnt_inc == blk_len);
      // Truncating mean
      mean     = acc_sum >> cfg_i.avg_log2;
   end

   always_ff @(posedge ana_del_clk, negedge rst_n) begin
      if (!rst_n) begin
         acc_q       <= '0;
         cnt_q       <= '0;
         log2_q      <= 2'd0;
         avg_valid_q <= 1'b0;
      end else begin
         log2_q      <= cfg_i.avg_log2;
         avg_valid_q <= blk_done;
         if (!cfg_i.conv_en || blk_done || (restart && !conv_valid_i)) begin
            acc_q <= '0;
            cnt_q <= '0;
         end else if (conv_valid_i) begin
            acc_q <= acc_sum;
            cnt_q <= cnt_inc;
         end
      end
   end

   // Mean held until the next block
   always_ff @(posedge ana_del_clk, negedge rst_n) begin
      if (!rst_n) begin
         avg_data_q <= '0;
      end else if (blk_done) begin
         avg_data_q <= mean[SAR_DATA_W-1:0];
      end
   end

   assign avg_data_o  = avg_data_q;
   assign avg_valid_o = avg_valid_q;

   ////////////////////
   // Checks
   ////////////////////

   a_avg_pulse : assert property (
      @(posedge ana_del_clk) disable iff (!rst_n)
      avg_valid_o |=> !avg_valid_o
   );

endmodule

// ==== src/sar_emulator.sv ====
`timescale 1ns/1ns

module sar_emulator
   import sar_conf_pkg::*, sar_data_pkg::*;
#(
   parameter int SAR_DATA_W = 8
) (
   input  logic                  ana_del_clk,
   input  logic                  rst_n,

   input  sar_cfg_t              cfg_i,

   // One word per period, zero when not valid
   output logic [SAR_DATA_W-1:0] conv_data_o,
   output logic                  conv_valid_o
);

   typedef enum logic {IDLE, APPLY} sar_state_e;

   sar_state_e              state_q, state_d;
   logic [7:0]              cnt_q, cnt_d;
   logic [LFSR_W-1:0]       lfsr_q, lfsr_d;
   logic [SAR_DATA_W-1:0]   ramp_q, ramp_d;
   sar_conv_t               conv;

   // One Galois step, feedback from bit 0
   function automatic logic [LFSR_W-1:0] lfsr_step(input logic [LFSR_W-1:0] cur);
      logic [LFSR_W-1:0] nxt;
      nxt = cur >> 1;
      if (cur[0]) begin
         nxt = nxt ^ LFSR_TAPS;
      end
      return nxt;
   endfunction

   ////////////////////
   // Period FSM
   ////////////////////

   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      lfsr_d  = lfsr_q;
      ramp_d  = ramp_q;
      conv    = '0;

      case (state_q)
         IDLE: begin
            // Period read live, new value hits next compare
            if (cnt_q == cfg_i.period_cnt) begin
               state_d = APPLY;
            end else begin
               cnt_d = cnt_q + 8'd1;
            end
         end
         APPLY: begin
            // LFSR keeps running even when disabled
            lfsr_d = lfsr_step(lfsr_q);
            if (cfg_i.conv_en) begin
               conv.valid = 1'b1;
               if (cfg_i.pattern_sel) begin
                  conv.word = LFSR_W'(ramp_q);
                  // Ramp moves only with a ramp word out
                  ramp_d    = ramp_q + 1'b1;
               end else begin
                  conv.word = lfsr_q;
               end
            end
            cnt_d   = 8'd0;
            state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge ana_del_clk, negedge rst_n) begin
      if (!rst_n) begin
         state_q <= IDLE;
         cnt_q   <= 8'd0;
         lfsr_q  <= LFSR_SEED;
         ramp_q  <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         lfsr_q  <= lfsr_d;
         ramp_q  <= ramp_d;
      end
   end

   // Trim to converter width
   assign conv_data_o  = conv.word[SAR_DATA_W-1:0];
   assign conv_valid_o = conv.valid;

   ////////////////////
   // Checks
   ////////////////////

   // No words while output disabled
   a_valid_en : assert property (
      @(posedge ana_del_clk) disable iff (!rst_n)
      conv_valid_o |-> cfg_i.conv_en
   );

   // APPLY lasts one cycle, so never back to back
   a_valid_pulse : assert property (
      @(posedge ana_del_clk) disable iff (!rst_n)
      conv_valid_o |=> !conv_valid_o
   );

endmodule

// ==== src/sar_sense_top.sv ====
`timescale 1ns/1ns

module sar_sense_top
   import sar_conf_pkg::*;
#(
   parameter int          SAR_DATA_W = 8,
   parameter int unsigned PERIOD_RST = 255
) (
   input  logic                   ana_del_clk,
   input  logic                   rst_n,

   // Configuration bus
   input  logic                   block_en_i,
   input  logic [CONF_DATA_W-1:0] conf_data_i,
   input  logic [CONF_OFFS_W-1:0] conf_offset_i,

   // Raw conversions
   output logic [SAR_DATA_W-1:0]  conv_data_o,
   output logic                   conv_valid_o,

   // Averaged conversions
   output logic [SAR_DATA_W-1:0]  avg_data_o,
   output logic                   avg_valid_o
);

   // Shared live configuration
   sar_cfg_t cfg;

   sar_conf_regs #(
      .PERIOD_RST (PERIOD_RST)
   ) i_conf_regs (
      .ana_del_clk   (ana_del_clk),
      .rst_n         (rst_n),
      .block_en_i    (block_en_i),
      .conf_data_i   (conf_data_i),
      .conf_offset_i (conf_offset_i),
      .cfg_o         (cfg)
   );

   sar_emulator #(
      .SAR_DATA_W (SAR_DATA_W)
   ) i_emulator (
      .ana_del_clk  (ana_del_clk),
      .rst_n        (rst_n),
      .cfg_i        (cfg),
      .conv_data_o  (conv_data_o),
      .conv_valid_o (conv_valid_o)
   );

   // Decimator taps the raw stream
   sar_decimator #(
      .SAR_DATA_W (SAR_DATA_W)
   ) i_decimator (
      .ana_del_clk  (ana_del_clk),
      .rst_n        (rst_n),
      .cfg_i        (cfg),
      .conv_data_i  (conv_data_o),
      .conv_valid_i (conv_valid_o),
      .avg_data_o   (avg_data_o),
      .avg_valid_o  (avg_valid_o)
   );

endmodule

// ==== test/sar_clk_gen.sv ====
`timescale 1ns/1ns

module sar_clk_gen #(
   parameter int PERIOD_NS  = 8,
   parameter int RST_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_n_o
);

   // Free running, starts low
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

   // Held over the first rising edges, let go on a falling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

// ==== test/sar_sense_tb.sv ====
`timescale 1ns/1ns

module sar_sense_tb
   import sar_conf_pkg::*, sar_data_pkg::*;
();

   localparam int SAR_DATA_W = 8;
   localparam int PERIOD_RST = 255;
   localparam int MAX_PERIOD = 9;
   localparam int N_ROWS     = 9;

   typedef enum logic [1:0] {MODE_OFF, MODE_RAMP, MODE_LFSR} mode_e;

   // One table row, config to program and what to observe
   typedef struct packed {
      mode_e       mode;
      logic [1:0]  log2;
      logic        wr_per;
      logic        stray;
      logic [7:0]  n_conv;
      logic [15:0] idle;
   } row_t;

   logic                   ana_del_clk;
   logic                   rst_n;
   logic                   block_en_i;
   logic [CONF_DATA_W-1:0] conf_data_i;
   logic [CONF_OFFS_W-1:0] conf_offset_i;
   logic [SAR_DATA_W-1:0]  conv_data_o;
   logic                   conv_valid_o;
   logic [SAR_DATA_W-1:0]  avg_data_o;
   logic                   avg_valid_o;

   row_t rows [N_ROWS];

   int seed = 32'h7457_f5ea;
   int value_errs = 0;
   int timing_errs = 0;
   int count_errs = 0;
   int cycles = 0;
   int cycle_limit = 0;

   // Table writes in flight, picked up on the next rising edge
   logic       pend_ctrl, pend_per, pend_en;
   logic [7:0] pend_period;

   // Interval and LFSR model state
   logic              in_apply, m_en, exp_valid;
   logic [7:0]        wait_cnt, m_period, exp_lfsr;
   logic [LFSR_W-1:0] lfsr_m;

   // Observation state
   mode_e      cur_mode;
   logic [1:0] cur_log2;
   int         cur_period;
   logic [7:0] ramp_next;
   int         avg_sum, avg_cnt;
   logic       avg_due;
   logic [7:0] avg_exp;
   int         tick_cyc, last_pulse, conv_row, avg_row;

   sar_clk_gen #(
      .PERIOD_NS  (8),
      .RST_CYCLES (2)
   ) i_clk_gen (
      .clk_o   (ana_del_clk),
      .rst_n_o (rst_n)
   );

   sar_sense_top #(
      .SAR_DATA_W (SAR_DATA_W),
      .PERIOD_RST (PERIOD_RST)
   ) UUT (
      .ana_del_clk   (ana_del_clk),
      .rst_n         (rst_n),
      .block_en_i    (block_en_i),
      .conf_data_i   (conf_data_i),
      .conf_offset_i (conf_offset_i),
      .conv_data_o   (conv_data_o),
      .conv_valid_o  (conv_valid_o),
      .avg_data_o    (avg_data_o),
      .avg_valid_o   (avg_valid_o)
   );

   // Right shift, taps folded in when a one drops out
   function automatic logic [LFSR_W-1:0] next_lfsr(input logic [LFSR_W-1:0] r);
      logic [LFSR_W-1:0] n;
      n = {1'b0, r[LFSR_W-1:1]};
      if (r[0]) begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   ////////////////////
   // Interval model
   ////////////////////

   // Count to period, one APPLY cycle, LFSR steps on leaving it
   always @(posedge ana_del_clk) begin
      if (!rst_n) begin
         in_apply  = 1'b0;
         wait_cnt  = 8'd0;
         lfsr_m    = LFSR_SEED;
         m_en      = 1'b0;
         m_period  = 8'(PERIOD_RST);
         exp_valid = 1'b0;
      end else begin
         if (in_apply) begin
            in_apply = 1'b0;
            wait_cnt = 8'd0;
            lfsr_m   = next_lfsr(lfsr_m);
         end else if (wait_cnt == m_period) begin
            in_apply = 1'b1;
         end else begin
            wait_cnt = wait_cnt + 8'd1;
         end
         // Table writes land on this edge
         if (pend_ctrl) begin
            m_en = pend_en;
         end
         if (pend_per) begin
            m_period = pend_period;
         end
         exp_valid = in_apply && m_en;
         exp_lfsr  = lfsr_m[7:0];
      end
   end

   // Hang guard
   always @(posedge ana_del_clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////
   // Per cycle checks
   ////////////////////

   task automatic check_cycle;
      logic [7:0] word;
      @(negedge ana_del_clk);
      tick_cyc++;
      // Mean owed by a block that closed last cycle
      assert (avg_valid_o == avg_due) else begin
         $display("[ERROR] %0t avg_valid_o is %b, expected %b", $time, avg_valid_o, avg_due);
         timing_errs++;
      end
      if (avg_due && avg_valid_o) begin
         assert (avg_data_o == avg_exp) else begin
            $display("[ERROR] %0t mean %0d, expected %0d", $time, avg_data_o, avg_exp);
            value_errs++;
         end
      end
      if (avg_valid_o) begin
         avg_row++;
      end
      avg_due = 1'b0;
      assert (conv_valid_o == exp_valid) else begin
         $display("[ERROR] %0t conv_valid_o is %b, expected %b", $time, conv_valid_o,
                  exp_valid);
         timing_errs++;
      end
      if (conv_valid_o) begin
         conv_row++;
         // Steady spacing once the new period is running
         if (last_pulse >= 0) begin
            assert (tick_cyc - last_pulse == cur_period + 2) else begin
               $display("[ERROR] %0t pulse spacing %0d, expected %0d", $time,
                        tick_cyc - last_pulse, cur_period + 2);
               timing_errs++;
            end
         end
         last_pulse = tick_cyc;
      end else begin
         assert (conv_data_o == '0) else begin
            $display("[ERROR] %0t data %0d while not valid", $time, conv_data_o);
            value_errs++;
         end
      end
      if (exp_valid) begin
         word = (cur_mode == MODE_RAMP) ? ramp_next : exp_lfsr;
         if (cur_mode == MODE_RAMP) begin
            ramp_next++;
         end
         if (conv_valid_o) begin
            assert (conv_data_o == word) else begin
               $display("[ERROR] %0t word %0d, expected %0d", $time, conv_data_o, word);
               value_errs++;
            end
         end
         // Averaging model
         avg_sum += word;
         avg_cnt++;
         if (avg_cnt == (1 << cur_log2)) begin
            avg_exp = 8'(avg_sum >> cur_log2);
            avg_due = 1'b1;
            avg_sum = 0;
            avg_cnt = 0;
         end
      end
   endtask

   ////////////////////
   // Bus driving
   ////////////////////

   task automatic write_reg(input logic [CONF_OFFS_W-1:0] offs,
                            input logic [CONF_DATA_W-1:0] data,
                            input logic is_ctrl, input logic is_per);
      block_en_i    = 1'b1;
      conf_offset_i = offs;
      conf_data_i   = data;
      pend_ctrl     = is_ctrl;
      pend_per      = is_per;
      check_cycle();
      block_en_i    = 1'b0;
      pend_ctrl     = 1'b0;
      pend_per      = 1'b0;
   endtask

   // Writes that must not touch any register
   task automatic stray_writes;
      int i;
      for (i = 0; i < 6; i++) begin
         conf_data_i = 16'($random(seed));
         if (i % 2 == 0) begin
            // Real offset, strobe low
            block_en_i    = 1'b0;
            conf_offset_i = (i % 4 == 0) ? OFFS_PERIOD : OFFS_CTRL;
         end else begin
            // Strobed, no register there
            block_en_i    = 1'b1;
            conf_offset_i = 4'(2 + ($unsigned($random(seed)) % 14));
         end
         check_cycle();
      end
      block_en_i = 1'b0;
   endtask

   task automatic program_row(input row_t r);
      sar_ctrl_t   ctrl;
      sar_period_t per;
      // Noise in reserved bits
      ctrl.rsvd        = 12'($random(seed));
      ctrl.conv_en     = (r.mode != MODE_OFF);
      ctrl.pattern_sel = (r.mode == MODE_RAMP);
      ctrl.avg_log2    = r.log2;
      // New block size or a disable drops the partial sum
      if (r.log2 != cur_log2 || r.mode == MODE_OFF) begin
         avg_sum = 0;
         avg_cnt = 0;
      end
      cur_mode = r.mode;
      cur_log2 = r.log2;
      pend_en  = ctrl.conv_en;
      conv_row = 0;
      avg_row  = 0;
      write_reg(OFFS_CTRL, ctrl, 1'b1, 1'b0);
      if (r.wr_per) begin
         cur_period     = 2 + ($unsigned($random(seed)) % 8);
         per.rsvd       = 8'($random(seed));
         per.period_cnt = 8'(cur_period);
         pend_period    = per.period_cnt;
         last_pulse     = -1;
         write_reg(OFFS_PERIOD, per, 1'b0, 1'b1);
      end
      if (r.stray) begin
         stray_writes();
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      int r;
      int total;
      block_en_i    = 1'b0;
      conf_data_i   = '0;
      conf_offset_i = '0;
      pend_ctrl     = 1'b0;
      pend_per      = 1'b0;
      pend_en       = 1'b0;
      pend_period   = 8'd0;
      cur_mode      = MODE_OFF;
      cur_log2      = 2'd0;
      cur_period    = PERIOD_RST;
      ramp_next     = 8'd0;
      avg_sum       = 0;
      avg_cnt       = 0;
      avg_due       = 1'b0;
      avg_exp       = 8'd0;
      tick_cyc      = 0;
      last_pulse    = -1;

      // mode, log2, period write, stray writes, conversions, idle cycles
      rows[0] = '{MODE_OFF,  2'd0, 1'b0, 1'b0, 8'd0,  16'd600};
      rows[1] = '{MODE_RAMP, 2'd0, 1'b1, 1'b0, 8'd12, 16'd0};
      rows[2] = '{MODE_LFSR, 2'd0, 1'b1, 1'b0, 8'd12, 16'd0};
      rows[3] = '{MODE_RAMP, 2'd1, 1'b1, 1'b0, 8'd8,  16'd0};
      rows[4] = '{MODE_RAMP, 2'd2, 1'b1, 1'b0, 8'd12, 16'd0};
      rows[5] = '{MODE_RAMP, 2'd3, 1'b1, 1'b0, 8'd24, 16'd0};
      rows[6] = '{MODE_RAMP, 2'd1, 1'b1, 1'b1, 8'd9,  16'd0};
      rows[7] = '{MODE_OFF,  2'd1, 1'b1, 1'b0, 8'd0,  16'd120};
      rows[8] = '{MODE_RAMP, 2'd2, 1'b1, 1'b0, 8'd12, 16'd0};

      // Longest interval per conversion, first interval may wrap the counter
      cycle_limit = 100;
      for (r = 0; r < N_ROWS; r++) begin
         cycle_limit += rows[r].n_conv * (MAX_PERIOD + 2) + rows[r].idle + 300;
      end

      @(posedge rst_n);
      for (r = 0; r < N_ROWS; r++) begin
         program_row(rows[r]);
         if (rows[r].n_conv == 0) begin
            repeat (rows[r].idle) check_cycle();
         end else begin
            while (conv_row < rows[r].n_conv) begin
               check_cycle();
            end
         end
         // Last mean trails by a cycle
         check_cycle();
         assert (conv_row == rows[r].n_conv) else begin
            $display("[ERROR] %0t row %0d saw %0d conversions, expected %0d", $time, r,
                     conv_row, rows[r].n_conv);
            count_errs++;
         end
         assert (avg_row == (rows[r].n_conv >> rows[r].log2)) else begin
            $display("[ERROR] %0t row %0d saw %0d means, expected %0d", $time, r,
                     avg_row, rows[r].n_conv >> rows[r].log2);
            count_errs++;
         end
      end

      total = value_errs + timing_errs + count_errs;
      $display("Errors: %0d value, %0d timing, %0d count", value_errs, timing_errs,
               count_errs);
      if (total == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
